/* bench/cross_bar_core_checker.sv */
`timescale 1ns/1ps

module cross_bar_core_checker (
  input logic                          clk_i,
  input logic                          rst_n_i,
  input xbar_pkg::ch_vec_t             ch_allow_in_i,
  input logic [xbar_pkg::NUM_BANK-1:0] bank_valid_i,
  input xbar_pkg::xbar_bank_req_t      bank_req_i [xbar_pkg::NUM_BANK],
  input logic [xbar_pkg::NUM_BANK-1:0] bank_allow_in_i
);

  import xbar_pkg::*;

  // buffers come out of reset empty
  allow_after_reset_a: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> (ch_allow_in_i == '1))
    else $error("channel allow-in low right after reset");

  for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
    // stalled bank keeps its request
    hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (bank_valid_i[b] && !bank_allow_in_i[b])
        |=> (bank_valid_i[b] && $stable(bank_req_i[b])))
      else $error("bank %0d request changed under back-pressure", b);

    // known channel, and the request really belongs to this bank
    ch_id_range_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      bank_valid_i[b] |-> ((bank_req_i[b].ch_id < CH_ID_W'(NUM_CH))
        && (bank_req_i[b].req.addr[BANK_SEL_LSB +: BANK_SEL_W] == BANK_SEL_W'(b))))
      else $error("bank %0d carries a bad channel id or another bank's request", b);
  end

endmodule

/* bench/cross_bar_core_tb.sv */
`timescale 1ns/1ps

module cross_bar_core_tb;

  import xbar_pkg::*;

  localparam int MAX_LINES = 64;

  logic                clk;
  logic                rst_n;
  ch_vec_t             ch_valid;
  xbar_req_t           ch_req [NUM_CH];
  ch_vec_t             ch_allow_in;
  logic [NUM_BANK-1:0] bank_valid;
  xbar_bank_req_t      bank_req [NUM_BANK];
  logic [NUM_BANK-1:0] bank_allow_in;

  // stimulus lines
  ch_vec_t             line_vmask [MAX_LINES];
  xbar_req_t           line_req   [MAX_LINES][NUM_CH];
  logic [NUM_BANK-1:0] line_amask [MAX_LINES];
  int                  num_lines;

  // scoreboard
  xbar_req_t           send_q [NUM_CH][$];
  xbar_req_t           acc_q  [NUM_CH][$];
  xbar_bank_req_t      exp_q  [NUM_BANK][$];
  int                  model_cnt [NUM_CH];
  int                  max_par;
  int                  err_count;
  logic [31:0]         lcg_state;

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  cross_bar_core dut_i (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .ch_valid_i      (ch_valid),
    .ch_req_i        (ch_req),
    .ch_allow_in_o   (ch_allow_in),
    .bank_valid_o    (bank_valid),
    .bank_req_o      (bank_req),
    .bank_allow_in_i (bank_allow_in)
  );

  bind cross_bar_core cross_bar_core_checker u_checker (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .ch_allow_in_i   (ch_allow_in_o),
    .bank_valid_i    (bank_valid_o),
    .bank_req_i      (bank_req_o),
    .bank_allow_in_i (bank_allow_in_i)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic stop_on_error();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("ERROR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic load_stimulus();
    int             fd;
    string          text;
    logic [31:0]    v [11];
    xbar_bank_req_t e;
    fd = $fopen("bench/xbar_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      stop_on_error();
    end
    num_lines = 0;
    while ($fgets(text, fd)) begin
      if (text.len() > 0 && text.getc(0) == "D") begin
        void'($sscanf(text, "D %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
                      v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]));
        line_vmask[num_lines] = v[0][NUM_CH-1:0];
        for (int c = 0; c < NUM_CH; c++) begin
          line_req[num_lines][c].op   = v[1 + 3 * c][OP_W-1:0];
          line_req[num_lines][c].addr = v[2 + 3 * c][ADDR_MSB-ADDR_LSB:0];
          line_req[num_lines][c].data = v[3 + 3 * c];
        end
        line_amask[num_lines] = v[10][NUM_BANK-1:0];
        num_lines++;
      end else if (text.len() > 0 && text.getc(0) == "E") begin
        void'($sscanf(text, "E %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4]));
        e.ch_id    = v[1][CH_ID_W-1:0];
        e.req.op   = v[2][OP_W-1:0];
        e.req.addr = v[3][ADDR_MSB-ADDR_LSB:0];
        e.req.data = v[4];
        exp_q[v[0]].push_back(e);
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------------------------------------
  // per cycle scoring, sampled mid cycle
  // ----------------------------------------------------------------------
  task automatic score_cycle();
    int             par;
    int             ch;
    ch_vec_t        popped;
    xbar_bank_req_t got;
    xbar_bank_req_t e;
    xbar_req_t      r;
    par    = 0;
    popped = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      check_value($sformatf("ch_allow_in_o[%0d]", c), ch_allow_in[c],
                  model_cnt[c] < BUF_DEPTH);
    end
    for (int b = 0; b < NUM_BANK; b++) begin
      if (bank_valid[b] && bank_allow_in[b]) begin
        par++;
        got = bank_req[b];
        check_value($sformatf("bank_req_o[%0d] bank select", b),
                    got.req.addr[BANK_SEL_LSB +: BANK_SEL_W], b);
        ch = got.ch_id;
        if (ch >= NUM_CH || acc_q[ch].size() == 0) begin
          $display("bank %0d sent a request that no channel has queued", b);
          stop_on_error();
        end
        r = acc_q[ch].pop_front();
        check_value($sformatf("bank_req_o[%0d].req", b), got.req, r);
        popped[ch] = 1'b1;
        if (exp_q[b].size() == 0) begin
          $display("bank %0d sent more requests than expected", b);
          stop_on_error();
        end
        e = exp_q[b].pop_front();
        check_value($sformatf("bank_req_o[%0d].ch_id", b), got.ch_id, e.ch_id);
        check_value($sformatf("bank_req_o[%0d].req", b), got.req, e.req);
      end
    end
    for (int c = 0; c < NUM_CH; c++) begin
      if (ch_valid[c] && ch_allow_in[c]) begin
        acc_q[c].push_back(send_q[c].pop_front());
        model_cnt[c]++;
      end
      if (popped[c]) begin
        model_cnt[c]--;
      end
    end
    if (par > max_par) begin
      max_par = par;
    end
  endtask

  function automatic bit all_done();
    for (int c = 0; c < NUM_CH; c++) begin
      if (send_q[c].size() != 0 || acc_q[c].size() != 0) return 1'b0;
    end
    for (int b = 0; b < NUM_BANK; b++) begin
      if (exp_q[b].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    int                  idx;
    int                  cycles;
    int                  limit;
    logic [NUM_BANK-1:0] cur_amask;
    ch_valid      = '0;
    bank_allow_in = '1;
    for (int c = 0; c < NUM_CH; c++) begin
      ch_req[c]    = '0;
      model_cnt[c] = 0;
    end
    max_par   = 0;
    err_count = 0;
    lcg_state = 32'd9;
    idx       = 0;
    cycles    = 0;
    cur_amask = '1;
    load_stimulus();
    limit = 4 * num_lines + 50;

    // reset state, checked once the first reset edge has passed
    @(posedge clk);
    while (!rst_n) begin
      @(negedge clk);
      check_value("bank_valid_o", bank_valid, '0);
      check_value("ch_allow_in_o", ch_allow_in, {NUM_CH{1'b1}});
      @(posedge clk);
    end

    forever begin
      #1;
      cycles++;
      if (cycles > limit) begin
        $display("timeout: the run went past %0d cycles without finishing", limit);
        stop_on_error();
      end
      if (idx < num_lines) begin
        lcg_state = lcg_next(lcg_state);
        // occasional idle gap keeps the last allow mask
        if (idx == 0 || lcg_state[17:16] != 2'b00) begin
          for (int c = 0; c < NUM_CH; c++) begin
            if (line_vmask[idx][c]) begin
              send_q[c].push_back(line_req[idx][c]);
            end
          end
          cur_amask = line_amask[idx];
          idx++;
        end
      end else begin
        cur_amask = '1;
      end
      for (int c = 0; c < NUM_CH; c++) begin
        ch_valid[c] = (send_q[c].size() != 0);
        ch_req[c]   = ch_valid[c] ? send_q[c][0] : '0;
      end
      bank_allow_in = cur_amask;
      @(negedge clk);
      if (cycles == 1) begin
        check_value("bank_valid_o", bank_valid, '0);
      end
      score_cycle();
      if (idx == num_lines && all_done()) begin
        break;
      end
      @(posedge clk);
    end

    check_value("parallel transfers", max_par >= 3, 1);
    if (err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 5;

  initial begin
    clk_o = 1'b0;
    forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
  end

  // release just after an edge, like the other inputs
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

/* bench/xbar_stimulus.txt */
# D vmask op0 addr0 data0 op1 addr1 data1 op2 addr2 data2 bank_allow (addr = line addr 31:4)
# E bank ch op addr data
D 7 1 0000102 a0000001 2 0000202 b0000001 3 0000302 c0000001 f
D 7 1 0000106 a0000002 2 0000206 b0000002 3 0000306 c0000002 f
E 2 0 1 0000102 a0000001
E 2 1 2 0000202 b0000001
E 2 2 3 0000302 c0000001
E 2 0 1 0000106 a0000002
E 2 1 2 0000206 b0000002
E 2 2 3 0000306 c0000002
D 0 0 0000000 00000000 0 0000000 00000000 0 0000000 00000000 f
D 0 0 0000000 00000000 0 0000000 00000000 0 0000000 00000000 f
D 0 0 0000000 00000000 0 0000000 00000000 0 0000000 00000000 f
D 0 0 0000000 00000000 0 0000000 00000000 0 0000000 00000000 f
D 0 0 0000000 00000000 0 0000000 00000000 0 0000000 00000000 f
D 0 0 0000000 00000000 0 0000000 00000000 0 0000000 00000000 f
D 7 0 0000410 d0000000 1 0000511 d1111111 2 0000613 d3333333 f
E 0 0 0 0000410 d0000000
E 1 1 1 0000511 d1111111
E 3 2 2 0000613 d3333333
D 0 0 0000000 00000000 0 0000000 00000000 0 0000000 00000000 f
D 0 0 0000000 00000000 0 0000000 00000000 0 0000000 00000000 f
D 3 3 0000701 e0000001 1 0000800 e1000000 0 0000000 00000000 d
D 1 3 0000705 e0000002 0 0000000 00000000 0 0000000 00000000 d
D 1 3 0000709 e0000003 0 0000000 00000000 0 0000000 00000000 d
D 0 0 0000000 00000000 0 0000000 00000000 0 0000000 00000000 d
D 0 0 0000000 00000000 0 0000000 00000000 0 0000000 00000000 d
D 0 0 0000000 00000000 0 0000000 00000000 0 0000000 00000000 d
D 0 0 0000000 00000000 0 0000000 00000000 0 0000000 00000000 f
D 0 0 0000000 00000000 0 0000000 00000000 0 0000000 00000000 f
E 1 0 3 0000701 e0000001
E 1 0 3 0000705 e0000002
E 1 0 3 0000709 e0000003
E 0 1 1 0000800 e1000000

/* cross_bar_core.f */
logic/xbar_pkg.sv
logic/xbar_channel_buffer.sv
logic/xbar_rr_arbiter.sv
logic/xbar_bank_port.sv
logic/cross_bar_core.sv
bench/tb_clock_gen.sv
bench/cross_bar_core_checker.sv
bench/cross_bar_core_tb.sv

/* logic/cross_bar_core.sv */
`timescale 1ns/1ps

module cross_bar_core (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // channel side
  input  xbar_pkg::ch_vec_t             ch_valid_i,
  input  xbar_pkg::xbar_req_t           ch_req_i [xbar_pkg::NUM_CH],
  output xbar_pkg::ch_vec_t             ch_allow_in_o,
  // bank side
  output logic [xbar_pkg::NUM_BANK-1:0] bank_valid_o,
  output xbar_pkg::xbar_bank_req_t      bank_req_o [xbar_pkg::NUM_BANK],
  input  logic [xbar_pkg::NUM_BANK-1:0] bank_allow_in_i
);

  import xbar_pkg::*;

  // channel-major
  logic [NUM_BANK-1:0] ch_want  [NUM_CH];
  wire  [NUM_BANK-1:0] ch_taken [NUM_CH];
  xbar_req_t           ch_head  [NUM_CH];
  // bank-major
  wire  ch_vec_t       bank_want  [NUM_BANK];
  ch_vec_t             bank_taken [NUM_BANK];

  // ----------------------------------------------------------------------
  // channel buffers
  // ----------------------------------------------------------------------
  for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
    xbar_channel_buffer u_buffer (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .valid_i     (ch_valid_i[c]),
      .allow_in_o  (ch_allow_in_o[c]),
      .req_i       (ch_req_i[c]),
      .taken_i     (ch_taken[c]),
      .bank_want_o (ch_want[c]),
      .head_o      (ch_head[c])
    );

    // swap want and taken between channel and bank order
    for (genvar b = 0; b < NUM_BANK; b++) begin : g_swap
      assign bank_want[b][c] = ch_want[c][b];
      assign ch_taken[c][b]  = bank_taken[b][c];
    end
  end

  // ----------------------------------------------------------------------
  // bank ports
  // ----------------------------------------------------------------------
  for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
    xbar_bank_port u_port (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .want_i     (bank_want[b]),
      .head_i     (ch_head),
      .allow_in_i (bank_allow_in_i[b]),
      .valid_o    (bank_valid_o[b]),
      .req_o      (bank_req_o[b]),
      .taken_o    (bank_taken[b])
    );
  end

endmodule

/* logic/xbar_bank_port.sv */
`timescale 1ns/1ps

module xbar_bank_port (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  xbar_pkg::ch_vec_t        want_i,
  input  xbar_pkg::xbar_req_t      head_i [xbar_pkg::NUM_CH],
  input  logic                     allow_in_i,
  output logic                     valid_o,
  output xbar_pkg::xbar_bank_req_t req_o,
  output xbar_pkg::ch_vec_t        taken_o
);

  import xbar_pkg::*;

  ch_vec_t grant;
  logic    advance;

  // ----------------------------------------------------------------------
  // arbitration
  // ----------------------------------------------------------------------
  assign valid_o = |want_i;
  assign advance = valid_o & allow_in_i;

  xbar_rr_arbiter u_arbiter (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (want_i),
    .advance_i (advance),
    .grant_o   (grant)
  );

  // grant only counts as taken once the bank accepts
  assign taken_o = allow_in_i ? grant : '0;

  // ----------------------------------------------------------------------
  // payload mux
  // ----------------------------------------------------------------------
  always_comb begin
    req_o = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      if (grant[c]) begin
        req_o.ch_id = CH_ID_W'(c);
        req_o.req   = head_i[c];
      end
    end
  end

endmodule

/* logic/xbar_channel_buffer.sv */
`timescale 1ns/1ps

module xbar_channel_buffer (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          valid_i,
  output logic                          allow_in_o,
  input  xbar_pkg::xbar_req_t           req_i,
  input  logic [xbar_pkg::NUM_BANK-1:0] taken_i,
  output logic [xbar_pkg::NUM_BANK-1:0] bank_want_o,
  output xbar_pkg::xbar_req_t           head_o
);

  import xbar_pkg::*;

  xbar_req_t              mem [BUF_DEPTH];
  logic [BUF_PTR_W-1:0]   wr_ptr;
  logic [BUF_PTR_W-1:0]   rd_ptr;
  logic [BUF_CNT_W-1:0]   count;
  logic                   push;
  logic                   pop;
  logic [BANK_SEL_W-1:0]  head_bank;

  // full check only, a same-cycle pop does not reopen the input
  assign allow_in_o = (count != BUF_CNT_W'(BUF_DEPTH));
  assign push       = valid_i & allow_in_o;
  // at most one bank can take the head
  assign pop        = |taken_i;

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == BUF_PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == BUF_PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // head routing
  // ----------------------------------------------------------------------
  assign head_o    = mem[rd_ptr];
  assign head_bank = head_o.addr[BANK_SEL_LSB +: BANK_SEL_W];

  always_comb begin
    bank_want_o = '0;
    // nothing to offer when empty
    if (count != '0) begin
      bank_want_o[head_bank] = 1'b1;
    end
  end

endmodule

/* logic/xbar_pkg.sv */
package xbar_pkg;

  // ----------------------------------------------------------------------
  // crossbar sizes
  // ----------------------------------------------------------------------
  localparam int NUM_CH       = 3;
  localparam int NUM_BANK     = 4;
  localparam int CH_ID_W      = 2;

  // request fields
  localparam int OP_W         = 2;
  localparam int ADDR_MSB     = 31;
  localparam int ADDR_LSB     = 4;
  localparam int DATA_W       = 32;

  // bank select sits in the low line address bits
  localparam int BANK_SEL_LSB = 4;
  localparam int BANK_SEL_W   = 2;

  // per channel buffer
  localparam int BUF_DEPTH    = 2;
  localparam int BUF_PTR_W    = $clog2(BUF_DEPTH);
  localparam int BUF_CNT_W    = $clog2(BUF_DEPTH + 1);

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------
  typedef logic [NUM_CH-1:0] ch_vec_t;

  typedef struct packed {
    logic [OP_W-1:0]          op;
    logic [ADDR_MSB:ADDR_LSB] addr;
    logic [DATA_W-1:0]        data;
  } xbar_req_t;

  // what a bank sees, tagged with the source channel
  typedef struct packed {
    logic [CH_ID_W-1:0] ch_id;
    xbar_req_t          req;
  } xbar_bank_req_t;

endpackage

/* logic/xbar_rr_arbiter.sv */
`timescale 1ns/1ps

module xbar_rr_arbiter (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  xbar_pkg::ch_vec_t req_i,
  input  logic              advance_i,
  output xbar_pkg::ch_vec_t grant_o
);

  import xbar_pkg::*;

  logic [CH_ID_W-1:0] ptr;
  logic [CH_ID_W-1:0] grant_idx;
  logic [CH_ID_W:0]   cand;
  logic               found;

  // search from ptr upward, wrapping past the last channel
  always_comb begin
    grant_o   = '0;
    grant_idx = '0;
    found     = 1'b0;
    cand      = '0;
    for (int i = 0; i < NUM_CH; i++) begin
      cand = {1'b0, ptr} + (CH_ID_W + 1)'(i);
      if (cand >= (CH_ID_W + 1)'(NUM_CH)) begin
        cand = cand - (CH_ID_W + 1)'(NUM_CH);
      end
      if (!found && req_i[cand[CH_ID_W-1:0]]) begin
        found                       = 1'b1;
        grant_idx                   = cand[CH_ID_W-1:0];
        grant_o[cand[CH_ID_W-1:0]]  = 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // priority pointer
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr <= '0;
    end else if (advance_i) begin
      // winner drops to lowest priority
      if (grant_idx == CH_ID_W'(NUM_CH - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= grant_idx + 1'b1;
      end
    end
  end

endmodule
